//--- Makefile
# Verilator build and run for the APB I2C master

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f apbI2c.f --top-module apbI2cTb -o simv

run: build
	./obj_dir/simv | tee run.log
	grep -q "^Done: no errors$$" run.log

lint:
	verilator --lint-only --timing -f apbI2c.f --top-module apbI2cTb

clean:
	rm -rf obj_dir run.log

//--- apbI2c.f
logic/apbI2cPkg.sv
logic/syncFifo.sv
logic/apbRegs.sv
logic/i2cByteEngine.sv
logic/i2cPads.sv
logic/apbI2cTop.sv
dv/i2cTargetModel.sv
dv/apbI2cTb.sv

//--- dv/apbI2cTb.sv
`timescale 1ns/1ps

module apbI2cTb import apbI2cPkg::*; ();

	localparam int fifoDepth = 8;
	// Worst case of 40 bytes x 11 SCL periods x 16 cycles at divider 3 plus wide margin
	localparam int cycleLimit = 20000;

	logic PCLK;
	logic PRESETn;
	logic PSEL;
	logic PENABLE;
	logic PWRITE;
	logic [31:0] PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic PREADY;
	logic PSLVERR;
	logic intTx;
	logic intRx;
	logic sclOen;
	logic sdaOen;
	logic sclLine;
	logic sdaLine;
	logic tgtSdaLow;

	int seed;
	int errors;
	int checks;
	int cycles;
	int wrBase;
	// Pending byte comparisons and expected target bytes
	i2cByteT expQ[$];
	i2cByteT actQ[$];
	string nameQ[$];
	i2cByteT wrExp[$];

	// Pull-ups where either side may pull a line low
	assign sclLine = ~sclOen;
	assign sdaLine = ~(sdaOen | tgtSdaLow);

	apbI2cTop #(.fifoDepth(fifoDepth), .syncStages(2)) dut_i (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA),
		.PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
		.intTx(intTx), .intRx(intRx),
		.sclOen(sclOen), .sdaOen(sdaOen),
		.sclPin(sclLine), .sdaPin(sdaLine)
	);

	i2cTargetModel #(.ownAddr(7'h2C)) tgt_i (
		.PCLK(PCLK), .scl(sclLine), .sda(sdaLine), .sdaLow(tgtSdaLow)
	);

	////////////////////////////////////////
	// Clock, timeout, comparing process
	////////////////////////////////////////

	initial
	begin
		PCLK = 1'b0;
		forever #20 PCLK = ~PCLK;
	end

	always @(posedge PCLK)
	begin
		cycles++;
		if (cycles >= cycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Done: errors found");
			$finish;
		end
	end

	// Drains queued byte comparisons
	always @(posedge PCLK)
	begin
		while (actQ.size() != 0)
			checkByte(nameQ.pop_front(), expQ.pop_front(), actQ.pop_front());
	end

	////////////////////////////////////////
	// Reference and compare tasks
	////////////////////////////////////////

	// Read byte k is A5 plus k and a written byte is the issued data
	function automatic i2cByteT expectByte(input logic isRead, input int k, input i2cCmdT issued);
		return isRead ? 8'hA5 + k[7:0] : issued.data;
	endfunction

	function automatic i2cCmdT makeCmd(input logic rd, input logic stop, input logic start,
		input i2cByteT data);
		i2cCmdT c;
		c.read = rd;
		c.stop = stop;
		c.start = start;
		c.data = data;
		return c;
	endfunction

	task checkByte(input string name, input i2cByteT exp, input i2cByteT act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task checkBit(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("Fail %s expected %b actual %b", name, exp, act);
		end
	endtask

	////////////////////////////////////////
	// APB driver
	////////////////////////////////////////

	task apbWrite(input logic [31:0] addr, input logic [31:0] data, output logic err);
		@(negedge PCLK);
		PSEL = 1'b1;
		PENABLE = 1'b0;
		PWRITE = 1'b1;
		PADDR = addr;
		PWDATA = data;
		@(negedge PCLK);
		PENABLE = 1'b1;
		#1;
		err = PSLVERR;
		checkBit("write PREADY", 1'b1, PREADY);
		@(negedge PCLK);
		PSEL = 1'b0;
		PENABLE = 1'b0;
	endtask

	task apbRead(input logic [31:0] addr, output logic [31:0] data, output logic err);
		@(negedge PCLK);
		PSEL = 1'b1;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = addr;
		@(negedge PCLK);
		PENABLE = 1'b1;
		#1;
		// Sampled in the access phase before the closing edge
		data = PRDATA;
		err = PSLVERR;
		checkBit("read PREADY", 1'b1, PREADY);
		@(negedge PCLK);
		PSEL = 1'b0;
		PENABLE = 1'b0;
	endtask

	task sendCmd(input i2cCmdT c, output logic err);
		apbWrite(addrTx, {21'd0, c}, err);
	endtask

	// Polls status until the masked bits match
	task waitStatus(input logic [31:0] mask, input logic [31:0] value);
		logic [31:0] rd;
		logic err;
		apbRead(addrStatus, rd, err);
		while ((rd & mask) != value)
			apbRead(addrStatus, rd, err);
	endtask

	// Queues target bytes against the bytes issued since the last call
	task compareTarget(input string name);
		checkWord({name, " count"}, wrExp.size(), tgt_i.wrCount - wrBase);
		for (int i = 0; i < wrExp.size(); i++)
		begin
			nameQ.push_back(name);
			expQ.push_back(wrExp[i]);
			actQ.push_back(tgt_i.wrMem[(wrBase + i) % 64]);
		end
		wrBase = tgt_i.wrCount;
		wrExp.delete();
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		logic err;
		logic [31:0] rd;
		logic [31:0] rnd;
		i2cCmdT c;
		PRESETn = 1'b0;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = 32'd0;
		PWDATA = 32'd0;
		seed = 23;
		errors = 0;
		checks = 0;
		cycles = 0;
		wrBase = 0;
		repeat (2) @(posedge PCLK);
		@(negedge PCLK);
		PRESETn = 1'b1;

		// Reset values and register readback
		checkBit("reset intTx", 1'b1, intTx);
		checkBit("reset intRx", 1'b0, intRx);
		checkBit("reset PREADY", 1'b0, PREADY);
		checkBit("reset PSLVERR", 1'b0, PSLVERR);
		checkBit("reset sclOen", 1'b0, sclOen);
		checkBit("reset sdaOen", 1'b0, sdaOen);
		apbRead(addrStatus, rd, err);
		checkWord("reset status", 32'd1, rd);
		rnd = $random(seed);
		apbWrite(addrConfig, rnd, err);
		apbRead(addrConfig, rd, err);
		checkWord("config readback", {18'd0, rnd[13:0]}, rd);
		rnd = $random(seed);
		apbWrite(addrTimeout, rnd, err);
		apbRead(addrTimeout, rd, err);
		checkWord("timeout readback", {18'd0, rnd[13:0]}, rd);
		apbWrite(addrTimeout, 32'd0, err);
		rnd = 32'd1 + ($unsigned($random(seed)) % 32'd3);
		apbWrite(addrConfig, rnd, err);

		// Write transaction of three random bytes
		sendCmd(makeCmd(1'b0, 1'b0, 1'b1, 8'h58), err);
		for (int i = 0; i < 3; i++)
		begin
			rnd = $random(seed);
			c = makeCmd(1'b0, i == 2, 1'b0, rnd[7:0]);
			sendCmd(c, err);
			wrExp.push_back(expectByte(1'b0, i, c));
		end
		checkBit("write busy intTx", 1'b0, intTx);
		waitStatus(32'h5, 32'h1);
		checkBit("write intTx", 1'b1, intTx);
		compareTarget("write data");

		// Read transaction of four bytes
		sendCmd(makeCmd(1'b0, 1'b0, 1'b1, 8'h59), err);
		for (int i = 0; i < 4; i++)
			sendCmd(makeCmd(1'b1, i == 3, 1'b0, 8'h00), err);
		waitStatus(32'h5, 32'h1);
		checkBit("intRx with data", 1'b1, intRx);
		for (int k = 0; k < 4; k++)
		begin
			apbRead(addrRx, rd, err);
			checkBit("rx read error", 1'b0, err);
			nameQ.push_back("read data");
			expQ.push_back(expectByte(1'b1, k, makeCmd(1'b1, 1'b0, 1'b0, 8'h00)));
			actQ.push_back(rd[7:0]);
		end
		@(negedge PCLK);
		checkBit("intRx after last read", 1'b0, intRx);

		// Unacknowledged address, sticky error and its clear
		sendCmd(makeCmd(1'b0, 1'b0, 1'b1, 8'h22), err);
		sendCmd(makeCmd(1'b0, 1'b1, 1'b0, 8'h00), err);
		waitStatus(32'h5, 32'h1);
		apbRead(addrStatus, rd, err);
		checkWord("status after nack", 32'h9, rd);
		sendCmd(makeCmd(1'b0, 1'b1, 1'b1, 8'h58), err);
		checkBit("tx write after nack", 1'b1, err);
		apbWrite(addrStatus, 32'd0, err);
		apbRead(addrStatus, rd, err);
		checkWord("status after clear", 32'd1, rd);
		compareTarget("nack data");

		// TX overflow on a slow bus and an empty RX read
		apbWrite(addrConfig, 32'd10, err);
		sendCmd(makeCmd(1'b0, 1'b0, 1'b1, 8'h58), err);
		checkBit("fifo first write", 1'b0, err);
		for (int i = 1; i <= fifoDepth; i++)
		begin
			rnd = $random(seed);
			c = makeCmd(1'b0, i >= fifoDepth - 1, 1'b0, rnd[7:0]);
			sendCmd(c, err);
			checkBit("fifo fill write", i == fifoDepth, err);
			if (i < fifoDepth)
				wrExp.push_back(expectByte(1'b0, i, c));
		end
		apbRead(addrRx, rd, err);
		checkBit("empty rx read", 1'b1, err);
		waitStatus(32'h5, 32'h1);
		compareTarget("fill data");

		// Idle timeout with the bus held
		apbWrite(addrConfig, 32'd1, err);
		apbWrite(addrTimeout, 32'd2, err);
		sendCmd(makeCmd(1'b0, 1'b0, 1'b1, 8'h58), err);
		waitStatus(32'h5, 32'h1);
		apbRead(addrStatus, rd, err);
		checkWord("timeout status", 32'h9, rd);

		// Let the comparing process drain
		repeat (2) @(posedge PCLK);
		@(negedge PCLK);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- dv/i2cTargetModel.sv
`timescale 1ns/1ps

module i2cTargetModel #(
	parameter logic [6:0] ownAddr = 7'h2C
) (
	input logic PCLK,
	// Resolved bus lines
	input logic scl,
	input logic sda,
	// 1 pulls SDA low
	output logic sdaLow
);

	// Bytes written by the master, in arrival order
	logic [7:0] wrMem [64];
	int wrCount;
	int bitIdx;
	int rdCount;
	logic [7:0] shiftIn;
	logic [7:0] txByte;
	logic prevScl;
	logic prevSda;
	logic selected;
	logic readMode;
	logic isAddr;
	logic afterAddr;
	logic readActive;
	logic masterAck;

	initial
	begin
		sdaLow <= 1'b0;
		prevScl = 1'b1;
		prevSda = 1'b1;
		wrCount = 0;
		bitIdx = 0;
		rdCount = 0;
		shiftIn = 8'h00;
		txByte = 8'h00;
		selected = 1'b0;
		readMode = 1'b0;
		isAddr = 1'b0;
		afterAddr = 1'b0;
		readActive = 1'b0;
		masterAck = 1'b0;
	end

	// Lines are sampled on the falling PCLK edge, away from the pad flops
	always @(negedge PCLK)
	begin
		if (scl && prevScl && prevSda && !sda)
		begin
			// START, read counting restarts per transaction
			bitIdx = 0;
			isAddr = 1'b1;
			selected = 1'b0;
			readActive = 1'b0;
			rdCount = 0;
			sdaLow <= 1'b0;
		end
		else if (scl && prevScl && !prevSda && sda)
		begin
			// STOP
			isAddr = 1'b0;
			selected = 1'b0;
			readActive = 1'b0;
			sdaLow <= 1'b0;
		end
		else if (scl && !prevScl)
		begin
			// Rising SCL, data bit or the ACK slot
			if (bitIdx < 8)
				shiftIn = {shiftIn[6:0], sda};
			else
				masterAck = !sda;
			bitIdx++;
		end
		else if (!scl && prevScl)
		begin
			if (bitIdx == 8)
			begin
				if (isAddr)
				begin
					isAddr = 1'b0;
					selected = (shiftIn[7:1] == ownAddr);
					readMode = shiftIn[0];
					afterAddr = selected;
					sdaLow <= selected;
				end
				else if (selected && !readMode)
				begin
					wrMem[wrCount[5:0]] = shiftIn;
					wrCount++;
					sdaLow <= 1'b1;
				end
				else
					// Master owns the ACK slot of a read byte
					sdaLow <= 1'b0;
			end
			else if (bitIdx == 9)
			begin
				bitIdx = 0;
				sdaLow <= 1'b0;
				// Next read byte after the address or a master ACK
				readActive = selected && readMode && (afterAddr || (readActive && masterAck));
				afterAddr = 1'b0;
				if (readActive)
				begin
					txByte = 8'hA5 + rdCount[7:0];
					rdCount++;
					sdaLow <= !txByte[7];
				end
			end
			else if (bitIdx >= 1 && readActive)
			begin
				txByte = txByte << 1;
				sdaLow <= !txByte[7];
			end
		end
		prevScl = scl;
		prevSda = sda;
	end

endmodule

//--- logic/apbI2cPkg.sv
package apbI2cPkg;

	////////////////////////////////////////
	// Register map and field widths
	////////////////////////////////////////

	// Config and timeout register width
	localparam int cfgWidth = 14;

	// APB byte addresses of the five registers
	localparam logic [31:0] addrTx = 32'd0;
	localparam logic [31:0] addrRx = 32'd4;
	localparam logic [31:0] addrConfig = 32'd8;
	localparam logic [31:0] addrTimeout = 32'd12;
	localparam logic [31:0] addrStatus = 32'd16;

	////////////////////////////////////////
	// Payload types
	////////////////////////////////////////

	// One received byte, also the PRDATA low byte on an RX read
	typedef logic [7:0] i2cByteT;

	// One TX FIFO entry, data sits in PWDATA[7:0], flags above it
	typedef struct packed {
		logic read;
		logic stop;
		logic start;
		i2cByteT data;
	} i2cCmdT;

	// Number of PWDATA bits taken into a command word
	localparam int cmdWidth = $bits(i2cCmdT);

endpackage

//--- logic/apbI2cTop.sv
`timescale 1ns/1ps

module apbI2cTop import apbI2cPkg::*; #(
	parameter int fifoDepth = 8,
	parameter int syncStages = 2
) (
	input logic PCLK,
	input logic PRESETn,
	// APB slave
	input logic PSEL,
	input logic PENABLE,
	input logic PWRITE,
	input logic [31:0] PADDR,
	input logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	// Interrupt levels
	output logic intTx,
	output logic intRx,
	// I2C pins
	output logic sclOen,
	output logic sdaOen,
	input logic sclPin,
	input logic sdaPin
);

	// Command path
	i2cCmdT txCmd;
	i2cCmdT txHead;
	logic txPush;
	logic txPop;
	logic txFull;
	logic txEmpty;
	// Receive path
	i2cByteT rxByte;
	i2cByteT rxHead;
	logic rxPush;
	logic rxPop;
	logic rxFull;
	logic rxEmpty;
	// Settings and events
	logic [cfgWidth-1:0] clkDiv;
	logic [cfgWidth-1:0] idleTimeout;
	logic busBusy;
	logic nackSeen;
	logic timeoutSeen;
	// Bus line drive and sense
	logic sclOe;
	logic sdaOe;
	logic sclIn;
	logic sdaIn;

	////////////////////////////////////////
	// Register front end
	////////////////////////////////////////

	apbRegs regs_i (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
		.PADDR(PADDR), .PWDATA(PWDATA),
		.PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
		.txFull(txFull), .txEmpty(txEmpty),
		.rxEmpty(rxEmpty), .rxHead(rxHead),
		.busBusy(busBusy), .nackSeen(nackSeen), .timeoutSeen(timeoutSeen),
		.txPush(txPush), .rxPop(rxPop), .txCmd(txCmd),
		.clkDiv(clkDiv), .idleTimeout(idleTimeout),
		.intTx(intTx), .intRx(intRx)
	);

	////////////////////////////////////////
	// FIFOs and byte engine
	////////////////////////////////////////

	// Commands toward the engine
	syncFifo #(.payloadT(i2cCmdT), .fifoDepth(fifoDepth)) txFifo_i (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.push(txPush), .pushData(txCmd),
		.pop(txPop), .head(txHead),
		.full(txFull), .empty(txEmpty)
	);

	// Received bytes back to the CPU
	syncFifo #(.payloadT(i2cByteT), .fifoDepth(fifoDepth)) rxFifo_i (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.push(rxPush), .pushData(rxByte),
		.pop(rxPop), .head(rxHead),
		.full(rxFull), .empty(rxEmpty)
	);

	i2cByteEngine engine_i (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.cmdEmpty(txEmpty), .cmd(txHead), .cmdPop(txPop),
		.rxFull(rxFull), .rxPush(rxPush), .rxByte(rxByte),
		.clkDiv(clkDiv), .idleTimeout(idleTimeout),
		.sclIn(sclIn), .sdaIn(sdaIn), .sclOe(sclOe), .sdaOe(sdaOe),
		.busBusy(busBusy), .nackSeen(nackSeen), .timeoutSeen(timeoutSeen)
	);

	// Pad stage
	i2cPads #(.syncStages(syncStages)) pads_i (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.sclOe(sclOe), .sdaOe(sdaOe),
		.sclPin(sclPin), .sdaPin(sdaPin),
		.sclOen(sclOen), .sdaOen(sdaOen),
		.sclIn(sclIn), .sdaIn(sdaIn)
	);

endmodule

//--- logic/apbRegs.sv
`timescale 1ns/1ps

module apbRegs import apbI2cPkg::*; (
	input logic PCLK,
	input logic PRESETn,
	// APB slave side
	input logic PSEL,
	input logic PENABLE,
	input logic PWRITE,
	input logic [31:0] PADDR,
	input logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	// FIFO state
	input logic txFull,
	input logic txEmpty,
	input logic rxEmpty,
	input i2cByteT rxHead,
	// Engine events
	input logic busBusy,
	input logic nackSeen,
	input logic timeoutSeen,
	// FIFO strobes
	output logic txPush,
	output logic rxPop,
	output i2cCmdT txCmd,
	// Engine settings
	output logic [cfgWidth-1:0] clkDiv,
	output logic [cfgWidth-1:0] idleTimeout,
	// Interrupt levels
	output logic intTx,
	output logic intRx
);

	logic access;
	logic isTx;
	logic isRx;
	logic isConfig;
	logic isTimeout;
	logic isStatus;
	logic decoded;
	logic txRefused;
	logic rxRefused;
	logic stickyErr;

	////////////////////////////////////////
	// Address decode and refusal
	////////////////////////////////////////

	// Access phase of any transfer
	assign access = PSEL & PENABLE;
	assign isTx = (PADDR == addrTx);
	assign isRx = (PADDR == addrRx);
	assign isConfig = (PADDR == addrConfig);
	assign isTimeout = (PADDR == addrTimeout);
	assign isStatus = (PADDR == addrStatus);
	assign decoded = isTx | isRx | isConfig | isTimeout | isStatus;

	// FIFO ports are locked while the sticky error is up
	assign txRefused = isTx & (stickyErr | (PWRITE & txFull));
	assign rxRefused = isRx & (stickyErr | (~PWRITE & rxEmpty));

	// No wait states, undecoded addresses complete with an error
	assign PREADY = access;
	assign PSLVERR = access & (~decoded | txRefused | rxRefused);

	// FIFO strobes only for accepted transfers
	assign txPush = access & PWRITE & isTx & ~txRefused;
	assign rxPop = access & ~PWRITE & isRx & ~rxRefused;
	assign txCmd = i2cCmdT'(PWDATA[cmdWidth-1:0]);

	// Read mux, RX head goes out without a register stage
	always_comb
	begin
		PRDATA = 32'd0;
		if (isRx)
			PRDATA = {24'd0, rxHead};
		else if (isConfig)
			PRDATA = {{(32-cfgWidth){1'b0}}, clkDiv};
		else if (isTimeout)
			PRDATA = {{(32-cfgWidth){1'b0}}, idleTimeout};
		else if (isStatus)
			PRDATA = {28'd0, stickyErr, busBusy, ~rxEmpty, txEmpty};
	end

	////////////////////////////////////////
	// Control registers
	////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			clkDiv <= '0;
			idleTimeout <= '0;
			stickyErr <= 1'b0;
			intTx <= 1'b1;
			intRx <= 1'b0;
		end
		else
		begin
			if (access & PWRITE & isConfig)
				clkDiv <= PWDATA[cfgWidth-1:0];
			if (access & PWRITE & isTimeout)
				idleTimeout <= PWDATA[cfgWidth-1:0];
			// An engine event wins over a clear in the same cycle
			if (nackSeen | timeoutSeen)
				stickyErr <= 1'b1;
			else if (access & PWRITE & isStatus)
				stickyErr <= 1'b0;
			// Interrupt levels, one cycle behind the FIFO flags
			intTx <= txEmpty;
			intRx <= ~rxEmpty;
		end
	end

endmodule

//--- logic/i2cByteEngine.sv
`timescale 1ns/1ps

module i2cByteEngine import apbI2cPkg::*; (
	input logic PCLK,
	input logic PRESETn,
	// Command FIFO head
	input logic cmdEmpty,
	input i2cCmdT cmd,
	output logic cmdPop,
	// Receive FIFO
	input logic rxFull,
	output logic rxPush,
	output i2cByteT rxByte,
	// Settings
	input logic [cfgWidth-1:0] clkDiv,
	input logic [cfgWidth-1:0] idleTimeout,
	// Bus lines, oe high pulls the line low
	input logic sclIn,
	input logic sdaIn,
	output logic sclOe,
	output logic sdaOe,
	// Status and events
	output logic busBusy,
	output logic nackSeen,
	output logic timeoutSeen
);

	// Hold waits with SCL low for a command or RX space
	typedef enum logic [2:0] {stIdle, stStart, stBit, stAck, stStop, stHold, stFlush} stateT;

	stateT state;
	logic [cfgWidth-1:0] qCnt;
	logic [1:0] phase;
	logic tick;
	logic lastQuarter;
	logic [2:0] bitCnt;
	i2cByteT shiftReg;
	logic sdaDrive;
	logic held;
	logic flushPend;
	logic isRead;
	logic holdIdle;
	logic [cfgWidth+3:0] idleCnt;
	logic [cfgWidth+3:0] idleLimit;

	// Start commands always send their byte
	assign isRead = cmd.read & ~cmd.start;
	// Quarter period is clkDiv+1 cycles
	assign tick = (qCnt >= clkDiv);
	assign lastQuarter = tick & (phase == 2'd3);
	assign idleLimit = {idleTimeout, 4'b0000};
	assign holdIdle = (state == stHold) & cmdEmpty;

	assign sdaOe = sdaDrive;
	assign busBusy = held;
	assign rxByte = shiftReg;
	assign rxPush = (state == stAck) & lastQuarter & isRead;
	// Pop at byte end, plus stray and flushed commands
	assign cmdPop = ((state == stAck) & lastQuarter) |
		((state == stIdle) & ~cmdEmpty & ~cmd.start) |
		((state == stFlush) & ~cmdEmpty);

	// SCL low in quarters 0 and 1 of each period
	always_comb
	begin
		case (state)
			stStart: sclOe = held & ~phase[1];
			stBit, stAck, stStop: sclOe = ~phase[1];
			stHold: sclOe = 1'b1;
			default: sclOe = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// Quarter period timer
	////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			qCnt <= '0;
			phase <= 2'd0;
		end
		else if (state inside {stIdle, stHold, stFlush})
		begin
			qCnt <= '0;
			phase <= 2'd0;
		end
		else if (tick)
		begin
			qCnt <= '0;
			phase <= phase + 2'd1;
		end
		else
			qCnt <= qCnt + 1'b1;
	end

	// Byte shifter, MSB first, SDA enters at the end of the high phase
	always_ff @(posedge PCLK)
	begin
		if (((state == stStart) & lastQuarter) | ((state == stHold) & ~cmdEmpty & ~cmd.start))
			shiftReg <= cmd.data;
		else if ((state == stBit) & lastQuarter)
			shiftReg <= {shiftReg[6:0], sdaIn};
	end

	////////////////////////////////////////
	// Byte sequencer
	////////////////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state <= stIdle;
			bitCnt <= 3'd0;
			sdaDrive <= 1'b0;
			held <= 1'b0;
			flushPend <= 1'b0;
			idleCnt <= '0;
			nackSeen <= 1'b0;
			timeoutSeen <= 1'b0;
		end
		else
		begin
			nackSeen <= 1'b0;
			timeoutSeen <= 1'b0;
			// Counts only while parked with nothing to send
			idleCnt <= holdIdle ? idleCnt + 1'b1 : '0;
			case (state)
				stIdle:
					// Both lines must read high before a START
					if (~cmdEmpty & cmd.start & sclIn & sdaIn)
						state <= stStart;
				stStart:
				begin
					// Release SDA, then pull it low under high SCL
					if (tick & (phase == 2'd0))
						sdaDrive <= 1'b0;
					if (tick & (phase == 2'd2))
						sdaDrive <= 1'b1;
					if (lastQuarter)
					begin
						held <= 1'b1;
						bitCnt <= 3'd7;
						state <= stBit;
					end
				end
				stBit:
				begin
					// SDA moves mid low phase, away from SCL edges
					if (tick & (phase == 2'd0))
						sdaDrive <= ~isRead & ~shiftReg[7];
					if (lastQuarter)
					begin
						if (bitCnt == 3'd0)
							state <= stAck;
						else
							bitCnt <= bitCnt - 3'd1;
					end
				end
				stAck:
				begin
					// ACK a read byte unless it is the last one
					if (tick & (phase == 2'd0))
						sdaDrive <= isRead & ~cmd.stop;
					if (lastQuarter)
					begin
						if (~isRead & sdaIn)
						begin
							nackSeen <= 1'b1;
							flushPend <= ~cmd.stop;
							state <= stStop;
						end
						else if (cmd.stop)
							state <= stStop;
						else
							state <= stHold;
					end
				end
				stHold:
				begin
					if (holdIdle & (idleTimeout != '0) & (idleCnt == idleLimit - 1'b1))
					begin
						timeoutSeen <= 1'b1;
						state <= stStop;
					end
					else if (~cmdEmpty & cmd.start)
						state <= stStart;
					else if (~cmdEmpty & ~(isRead & rxFull))
					begin
						bitCnt <= 3'd7;
						state <= stBit;
					end
				end
				stStop:
				begin
					// SDA low under low SCL, released under high SCL
					if (tick & (phase == 2'd0))
						sdaDrive <= 1'b1;
					if (tick & (phase == 2'd2))
						sdaDrive <= 1'b0;
					if (lastQuarter)
					begin
						held <= 1'b0;
						flushPend <= 1'b0;
						state <= flushPend ? stFlush : stIdle;
					end
				end
				stFlush:
					// Drop the rest of the failed transaction
					if (~cmdEmpty & cmd.stop)
						state <= stIdle;
				default:
					state <= stIdle;
			endcase
		end
	end

endmodule

//--- logic/i2cPads.sv
`timescale 1ns/1ps

module i2cPads #(
	parameter int syncStages = 2
) (
	input logic PCLK,
	input logic PRESETn,
	// From the engine
	input logic sclOe,
	input logic sdaOe,
	// Pin levels
	input logic sclPin,
	input logic sdaPin,
	// Open-drain enables, 1 pulls low
	output logic sclOen,
	output logic sdaOen,
	// Synchronized pin levels
	output logic sclIn,
	output logic sdaIn
);

	logic [syncStages-1:0] sclSync;
	logic [syncStages-1:0] sdaSync;

	assign sclIn = sclSync[syncStages-1];
	assign sdaIn = sdaSync[syncStages-1];

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			sclOen <= 1'b0;
			sdaOen <= 1'b0;
			// Idle bus reads high
			sclSync <= '1;
			sdaSync <= '1;
		end
		else
		begin
			// Flopped enables keep the pins free of decode glitches
			sclOen <= sclOe;
			sdaOen <= sdaOe;
			sclSync[0] <= sclPin;
			sdaSync[0] <= sdaPin;
			for (int i = 1; i < syncStages; i++)
			begin
				sclSync[i] <= sclSync[i-1];
				sdaSync[i] <= sdaSync[i-1];
			end
		end
	end

endmodule

//--- logic/syncFifo.sv
`timescale 1ns/1ps

module syncFifo #(
	parameter type payloadT = logic [7:0],
	parameter int fifoDepth = 8
) (
	input logic PCLK,
	input logic PRESETn,
	// Write side
	input logic push,
	input payloadT pushData,
	// Read side
	input logic pop,
	output payloadT head,
	// Flags
	output logic full,
	output logic empty
);

	// Pointer index width, one more bit tells laps apart
	localparam int ptrWidth = $clog2(fifoDepth);

	logic [ptrWidth:0] wrPtr;
	logic [ptrWidth:0] rdPtr;
	logic doPush;
	logic doPop;
	payloadT mem [fifoDepth];

	// Same index, different lap means full
	assign empty = (wrPtr == rdPtr);
	assign full = (wrPtr[ptrWidth] != rdPtr[ptrWidth]) &&
		(wrPtr[ptrWidth-1:0] == rdPtr[ptrWidth-1:0]);

	// Overflow and underflow requests are dropped
	assign doPush = push & ~full;
	assign doPop = pop & ~empty;

	// Head is read straight from the array
	assign head = mem[rdPtr[ptrWidth-1:0]];

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
		end
	end

	// Storage array
	always_ff @(posedge PCLK)
	begin
		if (doPush)
			mem[wrPtr[ptrWidth-1:0]] <= pushData;
	end

endmodule
